// File: verilog/sched_pkg.sv
package sched_pkg;

  // Field widths
  localparam int CORE_ID_W = 3;
  localparam int SLOT_W    = 5;
  localparam int PORT_W    = 2;
  localparam int HASH_W    = 32;

  // Returned for any address with no register behind it
  localparam logic [31:0] READ_DEFAULT = 32'hfefefefe;

  // Control message types sent by the cores
  typedef enum logic [1:0] {
    MSG_SLOT_RETURN = 2'd0,
    MSG_SLOT_INIT   = 2'd3
  } ctrl_msg_e;

  // For an init the slot field carries the number of slots
  typedef struct packed {
    ctrl_msg_e             msg_type;
    logic [CORE_ID_W-1:0]  core;
    logic [SLOT_W-1:0]     slot;
  } ctrl_msg_t;

  typedef enum logic [2:0] {
    HOST_INCOME_CORES = 3'b000,
    HOST_SLOT_COUNT   = 3'b010,
    HOST_SLOT_FLUSH   = 3'b011,
    HOST_DROP_COUNT   = 3'b111
  } host_addr_e;

  // sel is a core index for slot counts, a port index for drop counts
  typedef struct packed {
    logic                  write;
    host_addr_e            addr;
    logic [CORE_ID_W-1:0]  sel;
    logic [31:0]           data;
  } host_cmd_t;

  typedef struct packed {
    logic [HASH_W-1:0]     hash;
    logic [PORT_W-1:0]     port;
  } rx_req_t;

  typedef struct packed {
    logic                  drop;
    logic [CORE_ID_W-1:0]  core;
    logic [SLOT_W-1:0]     slot;
    logic [PORT_W-1:0]     port;
    logic [HASH_W-1:0]     hash;
  } sched_desc_t;

endpackage

// File: verilog/ctrl_msg_decoder.sv
module ctrl_msg_decoder import sched_pkg::*; #(
  parameter int CORE_COUNT = 8
) (
  input  logic                  clk,
  input  logic                  rst_r,
  input  logic                  ctrl_valid,
  input  ctrl_msg_t             ctrl_msg,
  output logic [CORE_COUNT-1:0] init_strobe,
  output logic [CORE_COUNT-1:0] return_strobe,
  output logic [SLOT_W-1:0]     slot_value
);

  logic [CORE_COUNT-1:0] core_hit;
  logic                  is_init;
  logic                  is_return;

  // One-hot of the addressed core, empty for a core number out of range
  always_comb begin
    core_hit = '0;
    for (int c = 0; c < CORE_COUNT; c++) begin
      core_hit[c] = (ctrl_msg.core == CORE_ID_W'(c));
    end
  end

  assign is_init   = ctrl_valid && (ctrl_msg.msg_type == MSG_SLOT_INIT);
  assign is_return = ctrl_valid && (ctrl_msg.msg_type == MSG_SLOT_RETURN);

  always_ff @(posedge clk) begin
    if (rst_r) begin
      init_strobe   <= '0;
      return_strobe <= '0;
    end else begin
      init_strobe   <= is_init ? core_hit : '0;
      return_strobe <= is_return ? core_hit : '0;
    end
  end

  // Slot number or init count, shared by all pools
  always_ff @(posedge clk) begin
    slot_value <= ctrl_msg.slot;
  end

endmodule

// File: verilog/host_cmd_regs.sv
module host_cmd_regs import sched_pkg::*; #(
  parameter int CORE_COUNT = 8,
  parameter int PORT_COUNT = 3
) (
  input  logic                  clk,
  input  logic                  rst_r,
  input  logic                  host_valid,
  input  host_cmd_t             host_cmd,
  input  logic [SLOT_W-1:0]     slot_counts [CORE_COUNT],
  input  logic [31:0]           drop_counts [PORT_COUNT],
  output logic [CORE_COUNT-1:0] income_cores,
  output logic [CORE_COUNT-1:0] flush,
  output logic                  host_rd_valid,
  output logic [31:0]           host_rd_data
);

  logic                 cmd_write;
  logic                 rd_valid_r;
  host_addr_e           rd_addr_r;
  logic [CORE_ID_W-1:0] rd_sel_r;
  logic [31:0]          rd_data_n;

  assign cmd_write = host_valid && host_cmd.write;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      income_cores  <= '0;
      flush         <= '0;
      rd_valid_r    <= 1'b0;
      host_rd_valid <= 1'b0;
    end else begin
      // Flush is a single-cycle pulse
      flush <= '0;
      if (cmd_write) begin
        case (host_cmd.addr)
          HOST_INCOME_CORES: income_cores <= host_cmd.data[CORE_COUNT-1:0];
          HOST_SLOT_FLUSH:   flush <= host_cmd.data[CORE_COUNT-1:0];
          default: ;
        endcase
      end
      rd_valid_r    <= host_valid && !host_cmd.write;
      host_rd_valid <= rd_valid_r;
    end
  end

  // First read stage captures address and index
  always_ff @(posedge clk) begin
    rd_addr_r    <= host_cmd.addr;
    rd_sel_r     <= host_cmd.sel;
    host_rd_data <= rd_data_n;
  end

  // Readback mux, out of range indexes read zero
  always_comb begin
    rd_data_n = READ_DEFAULT;
    case (rd_addr_r)
      HOST_INCOME_CORES: rd_data_n = 32'(income_cores);
      HOST_SLOT_COUNT: begin
        rd_data_n = '0;
        for (int c = 0; c < CORE_COUNT; c++) begin
          if (rd_sel_r == CORE_ID_W'(c)) rd_data_n = 32'(slot_counts[c]);
        end
      end
      HOST_DROP_COUNT: begin
        rd_data_n = '0;
        for (int p = 0; p < PORT_COUNT; p++) begin
          if (rd_sel_r == CORE_ID_W'(p)) rd_data_n = drop_counts[p];
        end
      end
      default: rd_data_n = READ_DEFAULT;
    endcase
  end

endmodule

// File: verilog/slot_pool.sv
module slot_pool import sched_pkg::*; #(
  parameter int SLOT_COUNT = 16
) (
  input  logic              clk,
  input  logic              rst_r,
  input  logic              flush,
  input  logic              init_strobe,
  input  logic              return_strobe,
  input  logic [SLOT_W-1:0] slot_value,
  input  logic              pop,
  output logic [SLOT_W-1:0] head_slot,
  output logic              head_valid,
  output logic [SLOT_W-1:0] count
);

  localparam int PTR_W = $clog2(SLOT_COUNT);

  logic [SLOT_W-1:0] slots [SLOT_COUNT];
  logic [PTR_W-1:0]  rd_ptr;
  logic [PTR_W-1:0]  wr_ptr;
  logic [SLOT_W-1:0] init_count;
  logic [PTR_W-1:0]  init_wr_ptr;
  logic              push;
  logic              take;

  // Circular pointer increment, SLOT_COUNT need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    ptr_next = (ptr == PTR_W'(SLOT_COUNT - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Init count larger than the pool is clamped
  assign init_count  = (slot_value > SLOT_W'(SLOT_COUNT)) ? SLOT_W'(SLOT_COUNT) : slot_value;
  assign init_wr_ptr = (init_count == SLOT_W'(SLOT_COUNT)) ? '0 : PTR_W'(init_count);

  // A return to a full pool is dropped
  assign push = return_strobe && (count != SLOT_W'(SLOT_COUNT));
  assign take = pop && head_valid;

  assign head_slot  = slots[rd_ptr];
  assign head_valid = (count != '0);

  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (init_strobe) begin
      rd_ptr <= '0;
      wr_ptr <= init_wr_ptr;
      count  <= init_count;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (take) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      count <= count + SLOT_W'(push) - SLOT_W'(take);
    end
  end

  // Init loads slots 1..SLOT_COUNT, only the first n are counted
  always_ff @(posedge clk) begin
    if (init_strobe) begin
      for (int i = 0; i < SLOT_COUNT; i++) begin
        slots[i] <= SLOT_W'(i + 1);
      end
    end else if (push) begin
      slots[wr_ptr] <= slot_value;
    end
  end

endmodule

// File: verilog/core_selector.sv
module core_selector import sched_pkg::*; #(
  parameter int CORE_COUNT      = 8,
  parameter int PORT_COUNT      = 3,
  parameter int HASH_SEL_OFFSET = 0
) (
  input  logic                  clk,
  input  logic                  rst_r,
  input  logic                  req_valid,
  input  rx_req_t               req,
  input  logic [CORE_COUNT-1:0] income_cores,
  input  logic [SLOT_W-1:0]     head_slots [CORE_COUNT],
  input  logic [CORE_COUNT-1:0] head_valids,
  output logic [CORE_COUNT-1:0] pops,
  output logic [31:0]           drop_counts [PORT_COUNT],
  output logic                  desc_valid,
  output sched_desc_t           desc
);

  rx_req_t              req_r;
  logic                 req_valid_r;
  logic [CORE_ID_W-1:0] hash_core;
  logic [CORE_ID_W-1:0] core_r;
  logic                 grant;

  // Core number from the selected hash bits, folded into the core range
  assign hash_core = CORE_ID_W'(req.hash[HASH_SEL_OFFSET +: CORE_ID_W] % CORE_COUNT);

  // Stage 1
  always_ff @(posedge clk) begin
    if (rst_r) begin
      req_valid_r <= 1'b0;
    end else begin
      req_valid_r <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    req_r  <= req;
    core_r <= hash_core;
  end

  // Stage 2 grants only on an income core with a free slot
  assign grant = req_valid_r && income_cores[core_r] && head_valids[core_r];

  always_comb begin
    pops         = '0;
    pops[core_r] = grant;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      desc_valid <= 1'b0;
    end else begin
      desc_valid <= req_valid_r;
    end
  end

  always_ff @(posedge clk) begin
    desc.drop <= !grant;
    desc.core <= core_r;
    desc.slot <= grant ? head_slots[core_r] : '0;
    desc.port <= req_r.port;
    desc.hash <= req_r.hash;
  end

  // Drops on a port outside PORT_COUNT are not counted
  always_ff @(posedge clk) begin
    if (rst_r) begin
      for (int p = 0; p < PORT_COUNT; p++) begin
        drop_counts[p] <= '0;
      end
    end else if (req_valid_r && !grant) begin
      for (int p = 0; p < PORT_COUNT; p++) begin
        if (req_r.port == PORT_W'(p)) begin
          drop_counts[p] <= drop_counts[p] + 1'b1;
        end
      end
    end
  end

endmodule

// File: verilog/flow_sched_top.sv
module flow_sched_top import sched_pkg::*; #(
  parameter int CORE_COUNT      = 8,
  parameter int PORT_COUNT      = 3,
  parameter int SLOT_COUNT      = 16,
  parameter int HASH_SEL_OFFSET = 0
) (
  input  logic        clk,
  input  logic        rst_r,
  input  logic        req_valid,
  input  rx_req_t     req,
  input  logic        ctrl_valid,
  input  ctrl_msg_t   ctrl_msg,
  input  logic        host_valid,
  input  host_cmd_t   host_cmd,
  output logic        desc_valid,
  output sched_desc_t desc,
  output logic        host_rd_valid,
  output logic [31:0] host_rd_data
);

  logic [CORE_COUNT-1:0] init_strobe;
  logic [CORE_COUNT-1:0] return_strobe;
  logic [SLOT_W-1:0]     slot_value;
  logic [CORE_COUNT-1:0] income_cores;
  logic [CORE_COUNT-1:0] flush;
  logic [CORE_COUNT-1:0] pops;
  logic [CORE_COUNT-1:0] head_valids;
  logic [SLOT_W-1:0]     head_slots  [CORE_COUNT];
  logic [SLOT_W-1:0]     slot_counts [CORE_COUNT];
  logic [31:0]           drop_counts [PORT_COUNT];

  ctrl_msg_decoder #(.CORE_COUNT(CORE_COUNT)) ctrl_dec (
    .clk, .rst_r, .ctrl_valid, .ctrl_msg,
    .init_strobe, .return_strobe, .slot_value
  );

  host_cmd_regs #(.CORE_COUNT(CORE_COUNT), .PORT_COUNT(PORT_COUNT)) host_regs (
    .clk, .rst_r, .host_valid, .host_cmd, .slot_counts, .drop_counts,
    .income_cores, .flush, .host_rd_valid, .host_rd_data
  );

  // One free-slot pool per core
  for (genvar c = 0; c < CORE_COUNT; c++) begin : g_pool
    slot_pool #(.SLOT_COUNT(SLOT_COUNT)) pool (
      .clk           (clk),
      .rst_r         (rst_r),
      .flush         (flush[c]),
      .init_strobe   (init_strobe[c]),
      .return_strobe (return_strobe[c]),
      .slot_value    (slot_value),
      .pop           (pops[c]),
      .head_slot     (head_slots[c]),
      .head_valid    (head_valids[c]),
      .count         (slot_counts[c])
    );
  end

  core_selector #(
    .CORE_COUNT(CORE_COUNT), .PORT_COUNT(PORT_COUNT), .HASH_SEL_OFFSET(HASH_SEL_OFFSET)
  ) selector (
    .clk, .rst_r, .req_valid, .req, .income_cores, .head_slots, .head_valids,
    .pops, .drop_counts, .desc_valid, .desc
  );

endmodule

// File: dv/tb_clock.sv
module tb_clock #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

// File: dv/flow_sched_checker.sv
module flow_sched_checker import sched_pkg::*; #(
  parameter int CORE_COUNT      = 8,
  parameter int PORT_COUNT      = 3,
  parameter int SLOT_COUNT      = 16,
  parameter int HASH_SEL_OFFSET = 0
) (
  input  logic        clk,
  input  logic        rst_r,
  input  logic        req_valid,
  input  rx_req_t     req,
  input  logic        ctrl_valid,
  input  ctrl_msg_t   ctrl_msg,
  input  logic        host_valid,
  input  host_cmd_t   host_cmd,
  input  logic        desc_valid,
  input  sched_desc_t desc,
  input  logic        host_rd_valid,
  input  logic [31:0] host_rd_data,
  output int          errors,
  output int          checks,
  output int          pending
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [SLOT_W-1:0]     pools [CORE_COUNT][$];
  logic [31:0]           drops [PORT_COUNT];
  logic [CORE_COUNT-1:0] mask;
  logic [CORE_COUNT-1:0] flush_d;
  sched_desc_t           desc_q [$];
  logic [31:0]           rd_q [$];
  rx_req_t               req_d;
  ctrl_msg_t             ctrl_d;
  host_cmd_t             host_d;
  logic                  req_dv;
  logic                  ctrl_dv;
  logic                  rd_dv;

  always @(posedge clk) begin
    sched_desc_t          want;
    logic [31:0]          rd_want;
    logic [CORE_ID_W-1:0] core;
    logic                 grant;
    logic                 full;
    if (rst_r) begin
      for (int c = 0; c < CORE_COUNT; c++) begin
        pools[c].delete();
      end
      for (int p = 0; p < PORT_COUNT; p++) begin
        drops[p] = '0;
      end
      desc_q.delete();
      rd_q.delete();
      mask    = '0;
      flush_d = '0;
      req_dv  = 1'b0;
      ctrl_dv = 1'b0;
      rd_dv   = 1'b0;
    end else begin
      // Outputs of this cycle against the oldest expected values
      if (desc_valid) begin
        checks++;
        want = (desc_q.size() != 0) ? desc_q.pop_front() : 'x;
        if (desc !== want) begin
          errors++;
          $display("Mismatch at %0d ns: descriptor %h, expected %h", $time, desc, want);
        end
      end
      if (host_rd_valid) begin
        checks++;
        rd_want = (rd_q.size() != 0) ? rd_q.pop_front() : 'x;
        if (host_rd_data !== rd_want) begin
          errors++;
          $display("Mismatch at %0d ns: read data %h, expected %h", $time, host_rd_data, rd_want);
        end
      end
      // Read mux sees the state of the cycle after the strobe
      if (rd_dv) begin
        case (host_d.addr)
          HOST_INCOME_CORES: rd_want = 32'(mask);
          HOST_SLOT_COUNT:   rd_want = (host_d.sel < CORE_COUNT) ? pools[host_d.sel].size() : 0;
          HOST_DROP_COUNT:   rd_want = (host_d.sel < PORT_COUNT) ? drops[host_d.sel] : 0;
          default:           rd_want = READ_DEFAULT;
        endcase
        rd_q.push_back(rd_want);
      end
      // Decision for the request registered at the last edge
      grant = 1'b0;
      core  = '0;
      if (req_dv) begin
        core      = CORE_ID_W'(((req_d.hash >> HASH_SEL_OFFSET) % (1 << CORE_ID_W)) % CORE_COUNT);
        grant     = mask[core] && (pools[core].size() != 0);
        want.drop = !grant;
        want.core = core;
        want.slot = grant ? pools[core][0] : '0;
        want.port = req_d.port;
        want.hash = req_d.hash;
        desc_q.push_back(want);
        if (!grant && req_d.port < PORT_COUNT) begin
          drops[req_d.port]++;
        end
      end
      // Pool writes land one cycle after the control strobe
      for (int c = 0; c < CORE_COUNT; c++) begin
        full = (pools[c].size() == SLOT_COUNT);
        if (flush_d[c]) begin
          pools[c].delete();
        end else if (ctrl_dv && ctrl_d.core == c && ctrl_d.msg_type == MSG_SLOT_INIT) begin
          pools[c].delete();
          for (int s = 1; s <= ctrl_d.slot && s <= SLOT_COUNT; s++) begin
            pools[c].push_back(SLOT_W'(s));
          end
        end else begin
          if (grant && core == c) begin
            void'(pools[c].pop_front());
          end
          if (ctrl_dv && ctrl_d.core == c && ctrl_d.msg_type == MSG_SLOT_RETURN && !full) begin
            pools[c].push_back(ctrl_d.slot);
          end
        end
      end
      if (host_valid && host_cmd.write && host_cmd.addr == HOST_INCOME_CORES) begin
        mask = host_cmd.data[CORE_COUNT-1:0];
      end
      flush_d = (host_valid && host_cmd.write && host_cmd.addr == HOST_SLOT_FLUSH) ?
                host_cmd.data[CORE_COUNT-1:0] : '0;
      req_dv  = req_valid;
      req_d   = req;
      ctrl_dv = ctrl_valid;
      ctrl_d  = ctrl_msg;
      rd_dv   = host_valid && !host_cmd.write;
      host_d  = host_cmd;
    end
    pending = desc_q.size() + rd_q.size() + int'(req_dv) + int'(rd_dv);
  end

endmodule

// File: dv/flow_sched_asserts.sv
module flow_sched_asserts import sched_pkg::*; #(
  parameter int SLOT_COUNT = 16
) (
  input logic        clk,
  input logic        rst_r,
  input logic        req_valid,
  input logic        desc_valid,
  input sched_desc_t desc,
  input logic        host_valid,
  input host_cmd_t   host_cmd,
  input logic        host_rd_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count;

  // Fixed two-cycle request latency
  desc_latency: assert property (@(posedge clk) disable iff (rst_r)
    desc_valid == $past(req_valid, 2))
    else begin
      fail_count++;
      $error("desc_valid does not follow req_valid by two cycles");
    end

  granted_slot_range: assert property (@(posedge clk) disable iff (rst_r)
    desc_valid && !desc.drop |-> desc.slot >= 1 && desc.slot <= SLOT_COUNT)
    else begin
      fail_count++;
      $error("Granted slot %0d is outside 1 to %0d", desc.slot, SLOT_COUNT);
    end

  drop_slot_zero: assert property (@(posedge clk) disable iff (rst_r)
    desc_valid && desc.drop |-> desc.slot == '0)
    else begin
      fail_count++;
      $error("Dropped descriptor carries slot %0d", desc.slot);
    end

  read_latency: assert property (@(posedge clk) disable iff (rst_r)
    host_rd_valid == $past(host_valid && !host_cmd.write, 2))
    else begin
      fail_count++;
      $error("host_rd_valid does not follow the read strobe by two cycles");
    end

endmodule

// File: dv/flow_sched_tb.sv
module flow_sched_tb import sched_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CORE_COUNT      = 8;
  localparam int PORT_COUNT      = 3;
  localparam int SLOT_COUNT      = 16;
  localparam int HASH_SEL_OFFSET = 0;

  logic                        clk;
  logic                        rst_r;
  logic                        req_valid;
  rx_req_t                     req;
  logic                        ctrl_valid;
  ctrl_msg_t                   ctrl_msg;
  logic                        host_valid;
  host_cmd_t                   host_cmd;
  logic                        desc_valid;
  sched_desc_t                 desc;
  logic                        host_rd_valid;
  logic [31:0]                 host_rd_data;
  int                          errors;
  int                          checks;
  int                          pending;
  int                          timeouts;
  int                          assert_fails;
  logic [31:0]                 lfsr_state = 32'hc8c4_1f4f;
  logic [CORE_ID_W+SLOT_W-1:0] issued [$];
  logic [CORE_ID_W-1:0]        victim;
  logic                        drained;

  tb_clock #(.PERIOD_NS(40)) clk_gen (.clk);

  flow_sched_top #(
    .CORE_COUNT(CORE_COUNT), .PORT_COUNT(PORT_COUNT),
    .SLOT_COUNT(SLOT_COUNT), .HASH_SEL_OFFSET(HASH_SEL_OFFSET)
  ) dut0 (.*);

  flow_sched_checker #(
    .CORE_COUNT(CORE_COUNT), .PORT_COUNT(PORT_COUNT),
    .SLOT_COUNT(SLOT_COUNT), .HASH_SEL_OFFSET(HASH_SEL_OFFSET)
  ) chk0 (.*);

  bind flow_sched_top flow_sched_asserts #(.SLOT_COUNT(SLOT_COUNT)) asserts0 (.*);

  // Taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  task automatic send_ctrl(input ctrl_msg_e kind, input int core, input int slot);
    @(posedge clk);
    ctrl_valid <= 1'b1;
    ctrl_msg   <= '{msg_type: kind, core: CORE_ID_W'(core), slot: SLOT_W'(slot)};
    @(posedge clk);
    ctrl_valid <= 1'b0;
  endtask

  // Reads wait for their data
  // Every command ends with three idle cycles
  task automatic host_access(input logic write, input host_addr_e addr, input int sel,
                             input logic [31:0] data);
    logic got;
    @(posedge clk);
    host_valid <= 1'b1;
    host_cmd   <= '{write: write, addr: addr, sel: CORE_ID_W'(sel), data: data};
    @(posedge clk);
    host_valid <= 1'b0;
    got = write;
    for (int i = 0; i < 8 && !got; i++) begin
      @(negedge clk);
      got = host_rd_valid;
    end
    if (!got) begin
      timeouts++;
      $display("Timeout: no read data for host address %0d", addr);
    end
    repeat (3) @(posedge clk);
  endtask

  // Every other request is aimed at one core
  task automatic send_requests(input int n, input logic [CORE_ID_W-1:0] target);
    logic [31:0] flow_hash;
    for (int i = 0; i < n; i++) begin
      flow_hash = rand_bits(HASH_W);
      if (i % 2 == 0) begin
        flow_hash[HASH_SEL_OFFSET +: CORE_ID_W] = target;
      end
      @(posedge clk);
      req_valid <= 1'b1;
      req       <= '{hash: flow_hash, port: PORT_W'(rand_bits(PORT_W))};
    end
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  initial begin
    rst_r      <= 1'b1;
    req_valid  <= 1'b0;
    req        <= '0;
    ctrl_valid <= 1'b0;
    ctrl_msg   <= '0;
    host_valid <= 1'b0;
    host_cmd   <= '0;
    repeat (16) @(posedge clk);
    rst_r <= 1'b0;
    for (int c = 0; c < CORE_COUNT; c++) begin
      send_ctrl(MSG_SLOT_INIT, c, rand_bits(SLOT_W));
    end
    host_access(1'b1, HOST_INCOME_CORES, 0, rand_bits(CORE_COUNT));
    // Requests mixed with returns of slots already handed out
    for (int i = 0; i < 400; i++) begin
      @(posedge clk);
      if (desc_valid && !desc.drop) begin
        issued.push_back({desc.core, desc.slot});
      end
      req_valid  <= (rand_bits(1) != 0);
      req        <= '{hash: rand_bits(HASH_W), port: PORT_W'(rand_bits(PORT_W))};
      ctrl_valid <= 1'b0;
      if (issued.size() != 0 && rand_bits(1) != 0) begin
        ctrl_valid <= 1'b1;
        ctrl_msg   <= '{msg_type: MSG_SLOT_RETURN, core: issued[0][SLOT_W +: CORE_ID_W],
                        slot: issued[0][SLOT_W-1:0]};
        void'(issued.pop_front());
      end
    end
    @(posedge clk);
    req_valid  <= 1'b0;
    ctrl_valid <= 1'b0;
    repeat (4) @(posedge clk);
    victim = rand_bits(CORE_ID_W);
    host_access(1'b1, HOST_INCOME_CORES, 0, rand_bits(CORE_COUNT) | (32'd1 << victim));
    host_access(1'b1, HOST_SLOT_FLUSH, 0, 32'd1 << victim);
    send_requests(40, victim);
    send_ctrl(MSG_SLOT_INIT, victim, 4);
    send_requests(12, victim);
    // Return strobed one cycle ahead of the request that takes it
    send_ctrl(MSG_SLOT_RETURN, victim, 2);
    req_valid <= 1'b1;
    req       <= '{hash: 32'(victim) << HASH_SEL_OFFSET, port: PORT_W'(1)};
    @(posedge clk);
    req_valid <= 1'b0;
    repeat (4) @(posedge clk);
    host_access(1'b0, HOST_INCOME_CORES, 0, '0);
    for (int c = 0; c < CORE_COUNT; c++) begin
      host_access(1'b0, HOST_SLOT_COUNT, c, '0);
    end
    for (int p = 0; p < PORT_COUNT; p++) begin
      host_access(1'b0, HOST_DROP_COUNT, p, '0);
    end
    host_access(1'b0, host_addr_e'(3'b001), 0, '0);
    drained = 1'b0;
    for (int i = 0; i < 20 && !drained; i++) begin
      @(negedge clk);
      drained = (pending == 0);
    end
    if (!drained) begin
      timeouts++;
      $display("Timeout: %0d descriptors or read results never arrived", pending);
    end
    assert_fails = dut0.asserts0.fail_count;
    $display("Checks: %0d, mismatches: %0d, timeouts: %0d, assertion failures: %0d",
             checks, errors, timeouts, assert_fails);
    if (errors == 0 && timeouts == 0 && assert_fails == 0 && checks > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
verilog/sched_pkg.sv
verilog/ctrl_msg_decoder.sv
verilog/host_cmd_regs.sv
verilog/slot_pool.sv
verilog/core_selector.sv
verilog/flow_sched_top.sv
dv/tb_clock.sv
dv/flow_sched_checker.sv
dv/flow_sched_asserts.sv
dv/flow_sched_tb.sv
